//--- Makefile
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module meshTb \
		-f sim.f -Mdir $(BUILD_DIR) -o meshTb
	./$(BUILD_DIR)/meshTb

clean:
	rm -rf $(BUILD_DIR)

//--- bench/meshTb.sv
`timescale 1ns/1ps

module meshTb import meshPkg::*; ();

    localparam int unsigned NumDma       = 2;
    localparam int unsigned MemWordsLog2 = 6;
    localparam int unsigned BankLatency  = 3;
    localparam int unsigned PortW        = $clog2(NumDma);
    localparam int unsigned ModelWords   = 2 << MemWordsLog2;
    localparam int unsigned ClkPeriod    = 4;
    localparam int unsigned ResetCycles  = 16;
    localparam int unsigned RandomTxns   = 80;
    localparam int unsigned CycleLimit   = 200 * 64 + ResetCycles;

    logic              clk = 1'b0;
    logic              arstN;
    logic [NumDma-1:0] dmaReq;
    logic [NumDma-1:0] dmaWrite;
    addrT [NumDma-1:0] dmaAddr;
    dataT [NumDma-1:0] dmaWdata;
    logic [NumDma-1:0] dmaAck;
    dataT [NumDma-1:0] dmaRdata;

    // Reference storage keyed by half select and word index
    dataT refMem   [ModelWords];
    logic refValid [ModelWords];

    dataT [NumDma-1:0] expData;
    logic [NumDma-1:0] expRead;
    logic [31:0]       rngState [NumDma];
    int unsigned       readsIssued;
    int unsigned       cycles = 0;

    always #(ClkPeriod / 2) clk = ~clk;

    meshTop #(
        .NumDma       (NumDma),
        .MemWordsLog2 (MemWordsLog2),
        .BankLatency  (BankLatency)
    ) dut_i (
        .clk_i      (clk),
        .arstN_i    (arstN),
        .dmaReq_i   (dmaReq),
        .dmaWrite_i (dmaWrite),
        .dmaAddr_i  (dmaAddr),
        .dmaWdata_i (dmaWdata),
        .dmaAck_o   (dmaAck),
        .dmaRdata_o (dmaRdata)
    );

    // ----------------------------------------
    // Reference model and helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Bit 15 picks the bank and bits above the index alias
    function automatic logic [MemWordsLog2:0] refKey(input addrT a);
        return {a[AddrWidth-1], a[MemWordsLog2+1:2]};
    endfunction

    function automatic dataT refRead(input addrT a);
        return refMem[refKey(a)];
    endfunction

    task automatic checkData(input dataT got, input dataT exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s read data %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic checkAck(input logic [NumDma-1:0] got, input logic [NumDma-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: ack bits %b, expected %b", $time, got, exp);
            $display("TB FAILED");
            $fatal(1, "ack level mismatch");
        end
    endtask

    // One four-phase transaction on port p
    task automatic runTxn(input logic [PortW-1:0] p, input logic wr, input addrT addr,
                          input dataT data);
        @(posedge clk);
        if (wr) begin
            refMem[refKey(addr)]   = data;
            refValid[refKey(addr)] = 1'b1;
        end else begin
            readsIssued++;
        end
        expData[p]  <= refRead(addr);
        expRead[p]  <= !wr;
        dmaWrite[p] <= wr;
        dmaAddr[p]  <= addr;
        dmaWdata[p] <= data;
        dmaReq[p]   <= 1'b1;
        @(negedge clk);
        while (!dmaAck[p]) @(negedge clk);
        @(posedge clk);
        dmaReq[p] <= 1'b0;
        @(negedge clk);
        while (dmaAck[p]) @(negedge clk);
    endtask

    // Port p keeps to word indices whose low bit is p
    task automatic randomStream(input logic [PortW-1:0] p);
        logic [31:0]             r;
        logic [MemWordsLog2-1:0] idx;
        addrT                    addr;
        logic                    wr;
        for (int n = 0; n < RandomTxns; n++) begin
            rngState[p] = xorshift(rngState[p]);
            r    = rngState[p];
            idx  = {r[MemWordsLog2:2], p};
            addr = {r[31], r[14:8], idx, 2'b00};
            // Unwritten words have no defined value yet
            wr   = r[30] || !refValid[{r[31], idx}];
            rngState[p] = xorshift(rngState[p]);
            runTxn(p, wr, addr, rngState[p]);
        end
    endtask

    // ----------------------------------------
    // Read data compare per port
    // ----------------------------------------

    for (genvar p = 0; p < NumDma; p++) begin : genCheck
        logic        prevAck = 1'b0;
        int unsigned checked = 0;
        always @(negedge clk) begin
            if (dmaAck[p] && !prevAck && expRead[p]) begin
                checkData(dmaRdata[p], expData[p], $sformatf("port %0d", p));
                checked <= checked + 1;
            end
            prevAck <= dmaAck[p];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles, transactions did not complete", cycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        arstN       = 1'b0;
        dmaReq      = '0;
        dmaWrite    = '0;
        dmaAddr     = '0;
        dmaWdata    = '0;
        expData     = '0;
        expRead     = '0;
        readsIssued = 0;
        rngState[0] = 32'h507;
        rngState[1] = xorshift(32'h507);
        for (int k = 0; k < ModelWords; k++) begin
            refMem[k]   = '0;
            refValid[k] = 1'b0;
        end
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;

        // Idle after reset
        repeat (8) begin
            @(negedge clk);
            checkAck(dmaAck, '0);
        end

        // Lower half through one hop
        runTxn(1'b0, 1'b1, 16'h0040, 32'h1234_5678);
        runTxn(1'b0, 1'b0, 16'h0040, '0);
        // Upper half through two hops
        runTxn(1'b0, 1'b1, 16'h80c0, 32'hcafe_f00d);
        runTxn(1'b0, 1'b0, 16'h80c0, '0);

        // Same index in both halves
        runTxn(1'b0, 1'b1, 16'h0014, 32'haaaa_0001);
        runTxn(1'b0, 1'b1, 16'h8014, 32'hbbbb_0002);
        runTxn(1'b0, 1'b0, 16'h0014, '0);
        runTxn(1'b0, 1'b0, 16'h8014, '0);
        // Differs only above the index bits
        runTxn(1'b0, 1'b1, 16'h7f14, 32'hcccc_0003);
        runTxn(1'b0, 1'b0, 16'h0014, '0);
        runTxn(1'b0, 1'b0, 16'h8014, '0);

        fork
            randomStream(1'b0);
            randomStream(1'b1);
        join

        repeat (4) @(negedge clk);
        checkAck(dmaAck, '0);
        if (genCheck[0].checked + genCheck[1].checked == readsIssued) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d reads were checked",
                     genCheck[0].checked + genCheck[1].checked, readsIssued);
            $display("TB FAILED");
            $fatal(1, "missing read responses");
        end
    end

endmodule

//--- bench/meshTop_props.sv
`timescale 1ns/1ps

module meshTopProps import meshPkg::*; #(
    parameter int unsigned NumDma = 2
) (
    input logic              clk_i,
    input logic              arstN_i,
    input logic [NumDma-1:0] dmaReq_i,
    input logic [NumDma-1:0] dmaWrite_i,
    input addrT [NumDma-1:0] dmaAddr_i,
    input dataT [NumDma-1:0] dmaWdata_i,
    input logic [NumDma-1:0] dmaAck_o
);

    // ----------------------------------------
    // Four-phase rules per DMA port
    // ----------------------------------------

    for (genvar p = 0; p < NumDma; p++) begin : genPort
        ackNeedsReq: assert property (@(posedge clk_i) disable iff (!arstN_i)
            $rose(dmaAck_o[p]) |-> dmaReq_i[p])
            else $error("ack rose without req on port %0d", p);

        // Payload held until the responder answers
        payloadStable: assert property (@(posedge clk_i) disable iff (!arstN_i)
            (dmaReq_i[p] && !dmaAck_o[p]) |=>
                ($stable(dmaAddr_i[p]) && $stable(dmaWrite_i[p]) && $stable(dmaWdata_i[p])))
            else $error("payload changed during request on port %0d", p);

        ackDropsAfterReq: assert property (@(posedge clk_i) disable iff (!arstN_i)
            $fell(dmaAck_o[p]) |-> !dmaReq_i[p])
            else $error("ack dropped while req high on port %0d", p);
    end

endmodule

bind meshTop meshTopProps #(.NumDma(NumDma)) props (
    .clk_i      (clk_i),
    .arstN_i    (arstN_i),
    .dmaReq_i   (dmaReq_i),
    .dmaWrite_i (dmaWrite_i),
    .dmaAddr_i  (dmaAddr_i),
    .dmaWdata_i (dmaWdata_i),
    .dmaAck_o   (dmaAck_o)
);

//--- common/meshPkg.sv
package meshPkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------

    // Byte address width of a DMA port
    localparam int unsigned AddrWidth = 16;

    // Width of one data word
    localparam int unsigned DataWidth = 32;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    // DMA byte address, top bit picks the branch
    typedef logic [AddrWidth-1:0] addrT;

    // One data word, write or read
    typedef logic [DataWidth-1:0] dataT;

    // ----------------------------------------
    // FSM encodings
    // ----------------------------------------

    // Relay stage between two mesh levels
    typedef enum logic [1:0] {
        HopIdle,
        HopFwd,
        HopAck,
        HopDrain
    } hopStateT;

    // Memory bank responder
    typedef enum logic [1:0] {
        BankIdle,
        BankWait,
        BankAck
    } bankStateT;

endpackage

//--- sim.f
common/meshPkg.sv
xbar/reqArbiter.sv
xbar/meshXbar.sv
source/hopStage.sv
source/memBank.sv
source/meshTop.sv
bench/meshTop_props.sv
bench/meshTb.sv

//--- source/hopStage.sv
`timescale 1ns/1ps

module hopStage import meshPkg::*; (
    input  logic clk_i,
    input  logic arstN_i,

    // Toward the requester
    input  logic upReq_i,
    input  logic upWrite_i,
    input  addrT upAddr_i,
    input  dataT upWdata_i,
    output logic upAck_o,
    output dataT upRdata_o,

    // Toward the responder
    output logic dnReq_o,
    output logic dnWrite_o,
    output addrT dnAddr_o,
    output dataT dnWdata_o,
    input  logic dnAck_i,
    input  dataT dnRdata_i
);

    hopStateT state;
    hopStateT stateNext;

    logic writeQ;
    addrT addrQ;
    dataT wdataQ;
    dataT rdataQ;

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------

    always_comb begin
        stateNext = state;
        unique case (state)
            HopIdle:  if (upReq_i)  stateNext = HopFwd;
            HopFwd:   if (dnAck_i)  stateNext = HopAck;
            HopAck:   if (!upReq_i) stateNext = HopDrain;
            HopDrain: if (!dnAck_i) stateNext = HopIdle;
            default:  stateNext = HopIdle;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= HopIdle;
        end else begin
            state <= stateNext;
        end
    end

    // Payload captured as the request enters
    always_ff @(posedge clk_i) begin
        if ((state == HopIdle) && upReq_i) begin
            writeQ <= upWrite_i;
            addrQ  <= upAddr_i;
            wdataQ <= upWdata_i;
        end
        // Read data held until the next response
        if ((state == HopFwd) && dnAck_i) begin
            rdataQ <= dnRdata_i;
        end
    end

    assign dnReq_o   = (state == HopFwd) || (state == HopAck);
    assign dnWrite_o = writeQ;
    assign dnAddr_o  = addrQ;
    assign dnWdata_o = wdataQ;

    assign upAck_o   = (state == HopAck) || (state == HopDrain);
    assign upRdata_o = rdataQ;

endmodule

//--- source/memBank.sv
`timescale 1ns/1ps

module memBank import meshPkg::*; #(
    parameter int unsigned MemWordsLog2 = 6,
    parameter int unsigned BankLatency  = 3
) (
    input  logic clk_i,
    input  logic arstN_i,
    input  logic req_i,
    input  logic write_i,
    input  addrT addr_i,
    input  dataT wdata_i,
    output logic ack_o,
    output dataT rdata_o
);

    localparam int unsigned WordCount = 1 << MemWordsLog2;
    localparam int unsigned CntWidth  = $clog2(BankLatency + 1);

    bankStateT state;
    logic [CntWidth-1:0] cnt;
    logic [MemWordsLog2-1:0] wordIdx;
    logic fire;

    dataT mem [WordCount];
    dataT rdataQ;

    // Word index above the byte offset, higher bits alias
    assign wordIdx = addr_i[MemWordsLog2+1:2];

    // Last wait cycle, response goes out on this edge
    assign fire = (state == BankWait) && (cnt == '0);

    // ----------------------------------------
    // Latency FSM
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= BankIdle;
            cnt   <= '0;
        end else begin
            unique case (state)
                BankIdle: begin
                    if (req_i) begin
                        state <= BankWait;
                        cnt   <= CntWidth'(BankLatency - 1);
                    end
                end
                BankWait: begin
                    if (cnt == '0) begin
                        state <= BankAck;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                BankAck:  if (!req_i) state <= BankIdle;
                default:  state <= BankIdle;
            endcase
        end
    end

    // Storage access, write lands as ack rises
    always_ff @(posedge clk_i) begin
        if (fire) begin
            rdataQ <= mem[wordIdx];
            if (write_i) begin
                mem[wordIdx] <= wdata_i;
            end
        end
    end

    assign ack_o   = (state == BankAck);
    assign rdata_o = rdataQ;

endmodule

//--- source/meshTop.sv
`timescale 1ns/1ps

module meshTop import meshPkg::*; #(
    parameter int unsigned NumDma       = 2,
    parameter int unsigned MemWordsLog2 = 6,
    parameter int unsigned BankLatency  = 3
) (
    input  logic              clk_i,
    input  logic              arstN_i,
    input  logic [NumDma-1:0] dmaReq_i,
    input  logic [NumDma-1:0] dmaWrite_i,
    input  addrT [NumDma-1:0] dmaAddr_i,
    input  dataT [NumDma-1:0] dmaWdata_i,
    output logic [NumDma-1:0] dmaAck_o,
    output dataT [NumDma-1:0] dmaRdata_o
);

    // Crossbar outputs
    logic [1:0] xReq;
    logic [1:0] xWrite;
    addrT [1:0] xAddr;
    dataT [1:0] xWdata;
    logic [1:0] xAck;
    dataT [1:0] xRdata;

    // Between the two hops of branch 0
    logic midReq;
    logic midWrite;
    addrT midAddr;
    dataT midWdata;
    logic midAck;
    dataT midRdata;

    // Bank ports, index is the bank number
    logic [1:0] bankReq;
    logic [1:0] bankWrite;
    addrT [1:0] bankAddr;
    dataT [1:0] bankWdata;
    logic [1:0] bankAck;
    dataT [1:0] bankRdata;

    // ----------------------------------------
    // Crossbar
    // ----------------------------------------

    meshXbar #(
        .NumDma     (NumDma)
    ) xbar (
        .clk_i      (clk_i),
        .arstN_i    (arstN_i),
        .inReq_i    (dmaReq_i),
        .inWrite_i  (dmaWrite_i),
        .inAddr_i   (dmaAddr_i),
        .inWdata_i  (dmaWdata_i),
        .inAck_o    (dmaAck_o),
        .inRdata_o  (dmaRdata_o),
        .outReq_o   (xReq),
        .outWrite_o (xWrite),
        .outAddr_o  (xAddr),
        .outWdata_o (xWdata),
        .outAck_i   (xAck),
        .outRdata_i (xRdata)
    );

    // ----------------------------------------
    // Branch 0, two hops
    // ----------------------------------------

    hopStage hop0First (
        .clk_i (clk_i), .arstN_i (arstN_i),
        .upReq_i (xReq[0]), .upWrite_i (xWrite[0]),
        .upAddr_i (xAddr[0]), .upWdata_i (xWdata[0]),
        .upAck_o (xAck[0]), .upRdata_o (xRdata[0]),
        .dnReq_o (midReq), .dnWrite_o (midWrite),
        .dnAddr_o (midAddr), .dnWdata_o (midWdata),
        .dnAck_i (midAck), .dnRdata_i (midRdata)
    );

    hopStage hop0Second (
        .clk_i (clk_i), .arstN_i (arstN_i),
        .upReq_i (midReq), .upWrite_i (midWrite),
        .upAddr_i (midAddr), .upWdata_i (midWdata),
        .upAck_o (midAck), .upRdata_o (midRdata),
        .dnReq_o (bankReq[0]), .dnWrite_o (bankWrite[0]),
        .dnAddr_o (bankAddr[0]), .dnWdata_o (bankWdata[0]),
        .dnAck_i (bankAck[0]), .dnRdata_i (bankRdata[0])
    );

    // ----------------------------------------
    // Branch 1, one hop
    // ----------------------------------------

    hopStage hop1 (
        .clk_i (clk_i), .arstN_i (arstN_i),
        .upReq_i (xReq[1]), .upWrite_i (xWrite[1]),
        .upAddr_i (xAddr[1]), .upWdata_i (xWdata[1]),
        .upAck_o (xAck[1]), .upRdata_o (xRdata[1]),
        .dnReq_o (bankReq[1]), .dnWrite_o (bankWrite[1]),
        .dnAddr_o (bankAddr[1]), .dnWdata_o (bankWdata[1]),
        .dnAck_i (bankAck[1]), .dnRdata_i (bankRdata[1])
    );

    // ----------------------------------------
    // Memory banks
    // ----------------------------------------

    for (genvar b = 0; b < 2; b++) begin : genBank
        memBank #(
            .MemWordsLog2 (MemWordsLog2),
            .BankLatency  (BankLatency)
        ) bank (
            .clk_i   (clk_i),
            .arstN_i (arstN_i),
            .req_i   (bankReq[b]),
            .write_i (bankWrite[b]),
            .addr_i  (bankAddr[b]),
            .wdata_i (bankWdata[b]),
            .ack_o   (bankAck[b]),
            .rdata_o (bankRdata[b])
        );
    end

endmodule

//--- xbar/meshXbar.sv
`timescale 1ns/1ps

module meshXbar import meshPkg::*; #(
    parameter int unsigned NumDma = 2
) (
    input  logic              clk_i,
    input  logic              arstN_i,

    // Requester side
    input  logic [NumDma-1:0] inReq_i,
    input  logic [NumDma-1:0] inWrite_i,
    input  addrT [NumDma-1:0] inAddr_i,
    input  dataT [NumDma-1:0] inWdata_i,
    output logic [NumDma-1:0] inAck_o,
    output dataT [NumDma-1:0] inRdata_o,

    // Branch side
    output logic [1:0]        outReq_o,
    output logic [1:0]        outWrite_o,
    output addrT [1:0]        outAddr_o,
    output dataT [1:0]        outWdata_o,
    input  logic [1:0]        outAck_i,
    input  dataT [1:0]        outRdata_i
);

    // Target output per input
    logic [NumDma-1:0] target;

    // Requests split by target output
    logic [1:0][NumDma-1:0] routedReq;

    logic [1:0][NumDma-1:0] grant;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    // Upper half goes to output 0 and lower half to output 1
    always_comb begin
        for (int i = 0; i < NumDma; i++) begin
            target[i]       = ~inAddr_i[i][AddrWidth-1];
            routedReq[0][i] = inReq_i[i] & ~target[i];
            routedReq[1][i] = inReq_i[i] & target[i];
        end
    end

    // ----------------------------------------
    // One arbiter per output
    // ----------------------------------------

    for (genvar o = 0; o < 2; o++) begin : genOut
        reqArbiter #(
            .NumDma    (NumDma)
        ) arbiter (
            .clk_i     (clk_i),
            .arstN_i   (arstN_i),
            .request_i (routedReq[o]),
            .busy_i    (outAck_i[o]),
            .grant_o   (grant[o]),
            .granted_o ()
        );

        // Forwarded only after the grant has been registered
        assign outReq_o[o] = |(routedReq[o] & grant[o]);
    end

    // ----------------------------------------
    // Forward path payload
    // ----------------------------------------

    always_comb begin
        outWrite_o = '0;
        outAddr_o  = '0;
        outWdata_o = '0;
        for (int o = 0; o < 2; o++) begin
            for (int i = 0; i < NumDma; i++) begin
                if (grant[o][i]) begin
                    outWrite_o[o] = inWrite_i[i];
                    outAddr_o[o]  = inAddr_i[i];
                    outWdata_o[o] = inWdata_i[i];
                end
            end
        end
    end

    // ----------------------------------------
    // Return path
    // ----------------------------------------

    // An input holds at most one grant at a time
    always_comb begin
        inAck_o   = '0;
        inRdata_o = '0;
        for (int o = 0; o < 2; o++) begin
            for (int i = 0; i < NumDma; i++) begin
                if (grant[o][i]) begin
                    inAck_o[i]   = outAck_i[o];
                    inRdata_o[i] = outRdata_i[o];
                end
            end
        end
    end

endmodule

//--- xbar/reqArbiter.sv
`timescale 1ns/1ps

module reqArbiter #(
    parameter int unsigned NumDma = 2
) (
    input  logic              clk_i,
    input  logic              arstN_i,
    input  logic [NumDma-1:0] request_i,
    input  logic              busy_i,
    output logic [NumDma-1:0] grant_o,
    output logic              granted_o
);

    localparam int unsigned IdxWidth = (NumDma > 1) ? $clog2(NumDma) : 1;

    logic [NumDma-1:0]   grantQ;
    logic [IdxWidth-1:0] lastIdx;
    logic [NumDma-1:0]   pick;
    logic [IdxWidth-1:0] pickIdx;
    logic                found;

    // Search starts one past the previous winner
    always_comb begin
        int unsigned idx;
        pick    = '0;
        pickIdx = lastIdx;
        found   = 1'b0;
        for (int unsigned k = 1; k <= NumDma; k++) begin
            idx = (int'(lastIdx) + k) % NumDma;
            if (!found && request_i[idx]) begin
                pick[idx] = 1'b1;
                pickIdx   = IdxWidth'(idx);
                found     = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Grant register
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            grantQ  <= '0;
            lastIdx <= '0;
        end else if (grantQ == '0) begin
            if (found) begin
                grantQ  <= pick;
                lastIdx <= pickIdx;
            end
        end else if (((request_i & grantQ) == '0) && !busy_i) begin
            // Handshake back at idle on both sides
            grantQ <= '0;
        end
    end

    assign grant_o   = grantQ;
    assign granted_o = |grantQ;

endmodule
